// ==== logic/xv_bus_pkg.sv ====
// register bus constants shared by the host ports, the arbiter and the register file
package xv_bus_pkg;

    localparam int REG_COUNT = 16;         // registers in the file
    localparam int REG_NUM_W = 4;          // register number width
    localparam int REG_W     = 16;         // register width
    localparam int BYTE_W    = 8;          // bus byte width

    localparam logic CS_ENABLED   = 1'b0;  // chip select is active low
    localparam logic RNW_READ     = 1'b1;  // read-not-write level for a read
    localparam logic RNW_WRITE    = 1'b0;  // and for a write
    localparam logic BYTESEL_EVEN = 1'b0;  // even byte is the high byte
    localparam logic BYTESEL_ODD  = 1'b1;  // odd byte is the low byte

endpackage

// ==== logic/xv_spi_pkg.sv ====
// SPI packet layout, imported by the SPI target, the bridge and the top level
package xv_spi_pkg;

    // command byte: CS WR RS BS R3 R2 R1 R0
    localparam int CMD_CS_BIT  = 7;                // cycle enable
    localparam int CMD_WR_BIT  = 6;                // write when set, read when clear
    localparam int CMD_RS_BIT  = 5;                // soft reset of the register file
    localparam int CMD_BS_BIT  = 4;                // byte select
    localparam int CMD_REG_LSB = 0;                // register number in bits 3..0

    localparam logic [7:0] SPI_IDLE_BYTE   = 8'hCB; // sent while no read data is ready
    localparam int         SCK_SYNC_STAGES = 2;     // synchronizer depth for the SPI pins

endpackage

// ==== logic/spi_target.sv ====
// SPI mode-0 peripheral sampled in the pclk domain, hands whole bytes to the bridge
`timescale 1ns/1ps

module spi_target
    import xv_spi_pkg::*;
#(
    parameter int SYNC_STAGES = SCK_SYNC_STAGES
) (
    input  logic       pclk,
    input  logic       rst_n_i,
    input  logic       spi_sck_i,
    input  logic       spi_copi_i,
    input  logic       spi_cs_n_i,
    output logic       spi_cipo_o,
    output logic       select_o,     // synchronized chip select, active high
    output logic       rx_strobe_o,  // one cycle, rx_byte_o valid
    output logic [7:0] rx_byte_o,
    output logic       tx_load_o,    // tx_byte_i taken this cycle
    input  logic [7:0] tx_byte_i
);

    logic [SYNC_STAGES-1:0] sck_sync, copi_sync, cs_n_sync;
    logic                   sck_prev, cs_n_prev;
    logic                   sck_s, cs_n_s, sck_rise, sck_fall, cs_fall;
    logic [2:0]             bit_cnt;
    logic [2:0]             strobe_pipe;   // delays the byte-done pulse
    logic [7:0]             rx_shift, tx_shift;

    assign sck_s    = sck_sync[SYNC_STAGES-1];
    assign cs_n_s   = cs_n_sync[SYNC_STAGES-1];
    assign sck_rise = sck_s & ~sck_prev & ~cs_n_s;      // sample edge
    assign sck_fall = ~sck_s & sck_prev & ~cs_n_s;      // launch edge
    assign cs_fall  = ~cs_n_s & cs_n_prev;

    // first byte loads at select, later ones on the falling edge that closes a byte
    assign tx_load_o   = cs_fall | (sck_fall & (bit_cnt == 3'd0));
    assign select_o    = ~cs_n_s;
    assign rx_strobe_o = strobe_pipe[2];
    assign rx_byte_o   = rx_shift;                      // stable until the next rising edge
    assign spi_cipo_o  = tx_shift[7];                   // MSB first

    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            sck_sync    <= '0;
            copi_sync   <= '0;
            cs_n_sync   <= '1;                          // deselected
            sck_prev    <= 1'b0;
            cs_n_prev   <= 1'b1;
            bit_cnt     <= 3'd0;
            strobe_pipe <= 3'd0;
            tx_shift    <= SPI_IDLE_BYTE;
        end else begin
            sck_sync    <= {sck_sync[SYNC_STAGES-2:0], spi_sck_i};
            copi_sync   <= {copi_sync[SYNC_STAGES-2:0], spi_copi_i};
            cs_n_sync   <= {cs_n_sync[SYNC_STAGES-2:0], spi_cs_n_i};
            sck_prev    <= sck_s;
            cs_n_prev   <= cs_n_s;
            strobe_pipe <= {strobe_pipe[1:0], sck_rise & (bit_cnt == 3'd7)};
            if (cs_n_s) begin
                bit_cnt <= 3'd0;                        // realign on every select
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;              // wraps after 8 bits
            end
            if (tx_load_o) begin
                tx_shift <= tx_byte_i;
            end else if (sck_fall) begin
                tx_shift <= {tx_shift[6:0], 1'b1};
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[6:0], copi_sync[SYNC_STAGES-1]};  // shift in MSB first
        end
    end

endmodule

// ==== logic/spi_bus_bridge.sv ====
// decodes SPI command/payload byte pairs into register requests for the arbiter
`timescale 1ns/1ps

module spi_bus_bridge
    import xv_bus_pkg::*;
    import xv_spi_pkg::*;
(
    input  logic                 pclk,
    input  logic                 rst_n_i,
    input  logic                 select_i,
    input  logic                 rx_strobe_i,
    input  logic [BYTE_W-1:0]    rx_byte_i,
    input  logic                 tx_load_i,
    output logic [BYTE_W-1:0]    tx_byte_o,
    output logic                 req_o,
    output logic                 wr_o,
    output logic                 bytesel_o,
    output logic [REG_NUM_W-1:0] reg_num_o,
    output logic [BYTE_W-1:0]    wdata_o,
    input  logic                 ack_i,
    input  logic [BYTE_W-1:0]    rdata_i,
    output logic                 soft_reset_o
);

    logic              payload_next;   // next byte is the payload byte
    logic              wr_pend;        // command asked for a write
    logic              tx_valid;       // read data waiting for the next byte
    logic [BYTE_W-1:0] tx_data;
    logic              new_rd, new_wr;

    assign new_rd    = rx_strobe_i & ~payload_next & rx_byte_i[CMD_CS_BIT] &
                       ~rx_byte_i[CMD_WR_BIT];         // reads go out on the command byte
    assign new_wr    = rx_strobe_i & payload_next & wr_pend;
    assign tx_byte_o = tx_valid ? tx_data : SPI_IDLE_BYTE;

    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            payload_next <= 1'b0;
            wr_pend      <= 1'b0;
            req_o        <= 1'b0;
            soft_reset_o <= 1'b0;
            tx_valid     <= 1'b0;
        end else begin
            soft_reset_o <= rx_strobe_i & ~payload_next & rx_byte_i[CMD_RS_BIT];
            if (!select_i) begin
                payload_next <= 1'b0;                  // packet aborted, expect a command
            end else if (rx_strobe_i) begin
                payload_next <= ~payload_next;
            end
            if (rx_strobe_i && !payload_next) begin
                wr_pend <= rx_byte_i[CMD_CS_BIT] & rx_byte_i[CMD_WR_BIT];
            end
            if (ack_i) req_o <= 1'b0;                  // held until acknowledged
            if (new_rd || new_wr) req_o <= 1'b1;
            if (tx_load_i || !select_i) tx_valid <= 1'b0;  // byte handed to the shifter
            if (ack_i && !wr_o) tx_valid <= 1'b1;
        end
    end

    always_ff @(posedge pclk) begin
        if (rx_strobe_i && !payload_next) begin        // fields come from the command byte
            wr_o      <= rx_byte_i[CMD_WR_BIT];
            bytesel_o <= rx_byte_i[CMD_BS_BIT];
            reg_num_o <= rx_byte_i[CMD_REG_LSB +: REG_NUM_W];
        end
        if (new_wr) wdata_o <= rx_byte_i;
        if (ack_i) tx_data <= rdata_i;
    end

    // one access in flight, the arbiter must answer before the next packet asks
    a_one_outstanding: assert property (@(posedge pclk) disable iff (!rst_n_i)
        (new_rd || new_wr) |-> (!req_o || ack_i))
        else $error("spi bridge request while previous request pending");

endmodule

// ==== logic/host_bus_port.sv ====
// parallel host bus front end, turns a chip-select cycle into one arbiter request
`timescale 1ns/1ps

module host_bus_port
    import xv_bus_pkg::*;
(
    input  logic                 pclk,
    input  logic                 rst_n_i,
    input  logic                 bus_cs_n_i,
    input  logic                 bus_rd_nwr_i,
    input  logic                 bus_bytesel_i,
    input  logic [REG_NUM_W-1:0] bus_reg_num_i,
    input  logic [BYTE_W-1:0]    bus_data_i,
    output logic [BYTE_W-1:0]    bus_data_o,
    output logic                 bus_out_en_o,
    output logic                 req_o,
    output logic                 wr_o,
    output logic                 bytesel_o,
    output logic [REG_NUM_W-1:0] reg_num_o,
    output logic [BYTE_W-1:0]    wdata_o,
    input  logic                 ack_i,
    input  logic [BYTE_W-1:0]    rdata_i
);

    logic [1:0]                 cs_n_sync, rnw_sync, bs_sync;
    logic [1:0][REG_NUM_W-1:0]  reg_sync;
    logic [1:0][BYTE_W-1:0]     data_sync;
    logic                       cs_n_prev, cs_s, cs_fall;
    logic                       rnw_q;      // latched read-not-write
    logic                       rd_ready;   // read byte captured, drive the bus
    logic [BYTE_W-1:0]          rd_byte;

    assign cs_s         = cs_n_sync[1];
    assign cs_fall      = (cs_s == CS_ENABLED) && (cs_n_prev != CS_ENABLED);
    assign wr_o         = (rnw_q == RNW_WRITE);
    assign bus_out_en_o = rd_ready & (cs_s == CS_ENABLED);  // drops as soon as cs is seen high
    assign bus_data_o   = rd_byte;

    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            cs_n_sync <= {2{~CS_ENABLED}};
            cs_n_prev <= ~CS_ENABLED;
            req_o     <= 1'b0;
            rd_ready  <= 1'b0;
        end else begin
            cs_n_sync <= {cs_n_sync[0], bus_cs_n_i};
            cs_n_prev <= cs_s;
            if (ack_i) req_o <= 1'b0;
            if (cs_fall) req_o <= 1'b1;                 // one request per bus cycle
            if (cs_s != CS_ENABLED) begin
                rd_ready <= 1'b0;
            end else if (ack_i && rnw_q == RNW_READ) begin
                rd_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        rnw_sync  <= {rnw_sync[0], bus_rd_nwr_i};        // fields ride the same two stages as cs
        bs_sync   <= {bs_sync[0], bus_bytesel_i};
        reg_sync  <= {reg_sync[0], bus_reg_num_i};
        data_sync <= {data_sync[0], bus_data_i};
        if (cs_fall) begin                               // hold fields until acknowledged
            rnw_q     <= rnw_sync[1];
            bytesel_o <= bs_sync[1];
            reg_num_o <= reg_sync[1];
            wdata_o   <= data_sync[1];
        end
        if (ack_i) rd_byte <= rdata_i;
    end

    a_no_overlap: assert property (@(posedge pclk) disable iff (!rst_n_i)
        cs_fall |-> !req_o)
        else $error("host bus cycle started while previous request pending");

endmodule

// ==== logic/reg_arbiter.sv ====
// round-robin arbiter giving the parallel port or the SPI bridge one register access
`timescale 1ns/1ps

module reg_arbiter
    import xv_bus_pkg::*;
(
    input  logic                 pclk,
    input  logic                 rst_n_i,
    input  logic                 h0_req_i,
    input  logic                 h0_wr_i,
    input  logic                 h0_bytesel_i,
    input  logic [REG_NUM_W-1:0] h0_reg_num_i,
    input  logic [BYTE_W-1:0]    h0_wdata_i,
    output logic                 h0_ack_o,
    output logic [BYTE_W-1:0]    h0_rdata_o,
    input  logic                 h1_req_i,
    input  logic                 h1_wr_i,
    input  logic                 h1_bytesel_i,
    input  logic [REG_NUM_W-1:0] h1_reg_num_i,
    input  logic [BYTE_W-1:0]    h1_wdata_i,
    output logic                 h1_ack_o,
    output logic [BYTE_W-1:0]    h1_rdata_o,
    output logic                 sel_o,
    output logic                 wr_o,
    output logic                 bytesel_o,
    output logic [REG_NUM_W-1:0] reg_num_o,
    output logic [BYTE_W-1:0]    wdata_o,
    input  logic [BYTE_W-1:0]    rdata_i
);

    logic elig0, elig1, gnt0, gnt1;
    logic ptr;     // host with priority on a tie
    logic busy;    // second cycle of an access, register file answering
    logic owner;   // host of the access in flight

    assign elig0 = h0_req_i & ~h0_ack_o;               // request still up during its ack
    assign elig1 = h1_req_i & ~h1_ack_o;
    assign gnt0  = ~busy & elig0 & (~elig1 | ~ptr);
    assign gnt1  = ~busy & elig1 & (~elig0 | ptr);

    assign sel_o     = gnt0 | gnt1;
    assign wr_o      = gnt1 ? h1_wr_i      : h0_wr_i;
    assign bytesel_o = gnt1 ? h1_bytesel_i : h0_bytesel_i;
    assign reg_num_o = gnt1 ? h1_reg_num_i : h0_reg_num_i;
    assign wdata_o   = gnt1 ? h1_wdata_i   : h0_wdata_i;

    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            ptr      <= 1'b0;
            busy     <= 1'b0;
            h0_ack_o <= 1'b0;
            h1_ack_o <= 1'b0;
        end else begin
            busy     <= sel_o;
            h0_ack_o <= busy & ~owner;                  // ack lands with the read byte
            h1_ack_o <= busy & owner;
            if (sel_o) ptr <= gnt0;                     // loser of this round wins the next
        end
    end

    always_ff @(posedge pclk) begin
        if (sel_o) owner <= gnt1;
        if (busy && !owner) h0_rdata_o <= rdata_i;
        if (busy && owner) h1_rdata_o <= rdata_i;
    end

    // a losing host must keep asking until its ack arrives
    a_h0_req_held: assert property (@(posedge pclk) disable iff (!rst_n_i)
        (h0_req_i && !h0_ack_o) |=> h0_req_i)
        else $error("parallel host dropped its request before the acknowledge");

    a_h1_req_held: assert property (@(posedge pclk) disable iff (!rst_n_i)
        (h1_req_i && !h1_ack_o) |=> h1_req_i)
        else $error("spi host dropped its request before the acknowledge");

endmodule

// ==== logic/xv_regs.sv ====
// register file of sixteen 16-bit registers written and read one byte at a time
`timescale 1ns/1ps

module xv_regs
    import xv_bus_pkg::*;
(
    input  logic                 pclk,
    input  logic                 rst_n_i,
    input  logic                 soft_reset_i,
    input  logic                 sel_i,
    input  logic                 wr_i,
    input  logic                 bytesel_i,
    input  logic [REG_NUM_W-1:0] reg_num_i,
    input  logic [BYTE_W-1:0]    wdata_i,
    output logic [BYTE_W-1:0]    rdata_o
);

    logic [REG_W-1:0] regs [REG_COUNT];

    always_ff @(posedge pclk) begin
        if (!rst_n_i || soft_reset_i) begin            // SPI RS bit clears like a hard reset
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (sel_i && wr_i) begin
            if (bytesel_i == BYTESEL_EVEN) begin
                regs[reg_num_i][REG_W-1 -: BYTE_W] <= wdata_i;  // high byte
            end else begin
                regs[reg_num_i][BYTE_W-1:0] <= wdata_i;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (sel_i) begin
            if (wr_i) begin
                rdata_o <= wdata_i;                    // writes echo the new byte
            end else if (bytesel_i == BYTESEL_ODD) begin
                rdata_o <= regs[reg_num_i][BYTE_W-1:0];
            end else begin
                rdata_o <= regs[reg_num_i][REG_W-1 -: BYTE_W];
            end
        end
    end

endmodule

// ==== logic/xv_host_top.sv ====
// host register subsystem top, wires both host ports through the arbiter to the registers
`timescale 1ns/1ps

module xv_host_top
    import xv_bus_pkg::*;
    import xv_spi_pkg::*;
(
    input  logic                 pclk,
    input  logic                 rst_n_i,
    input  logic                 bus_cs_n_i,
    input  logic                 bus_rd_nwr_i,
    input  logic                 bus_bytesel_i,
    input  logic [REG_NUM_W-1:0] bus_reg_num_i,
    input  logic [BYTE_W-1:0]    bus_data_i,
    output logic [BYTE_W-1:0]    bus_data_o,
    output logic                 bus_out_en_o,   // board drives the data pins from this
    input  logic                 spi_sck_i,
    input  logic                 spi_copi_i,
    input  logic                 spi_cs_n_i,
    output logic                 spi_cipo_o
);

    logic                 spi_select, spi_rx_strobe, spi_tx_load;
    logic [BYTE_W-1:0]    spi_rx_byte, spi_tx_byte;
    logic                 soft_reset;
    logic                 h0_req, h0_wr, h0_bytesel, h0_ack;   // parallel host
    logic [REG_NUM_W-1:0] h0_reg_num;
    logic [BYTE_W-1:0]    h0_wdata, h0_rdata;
    logic                 h1_req, h1_wr, h1_bytesel, h1_ack;   // SPI host
    logic [REG_NUM_W-1:0] h1_reg_num;
    logic [BYTE_W-1:0]    h1_wdata, h1_rdata;
    logic                 reg_sel, reg_wr, reg_bytesel;       // arbiter to register file
    logic [REG_NUM_W-1:0] reg_num;
    logic [BYTE_W-1:0]    reg_wdata, reg_rdata;

    spi_target #(.SYNC_STAGES(SCK_SYNC_STAGES)) u_spi_target (
        .pclk(pclk), .rst_n_i(rst_n_i),
        .spi_sck_i(spi_sck_i), .spi_copi_i(spi_copi_i), .spi_cs_n_i(spi_cs_n_i),
        .spi_cipo_o(spi_cipo_o), .select_o(spi_select),
        .rx_strobe_o(spi_rx_strobe), .rx_byte_o(spi_rx_byte),
        .tx_load_o(spi_tx_load), .tx_byte_i(spi_tx_byte)
    );

    spi_bus_bridge u_spi_bus_bridge (
        .pclk(pclk), .rst_n_i(rst_n_i), .select_i(spi_select),
        .rx_strobe_i(spi_rx_strobe), .rx_byte_i(spi_rx_byte),
        .tx_load_i(spi_tx_load), .tx_byte_o(spi_tx_byte),
        .req_o(h1_req), .wr_o(h1_wr), .bytesel_o(h1_bytesel), .reg_num_o(h1_reg_num),
        .wdata_o(h1_wdata), .ack_i(h1_ack), .rdata_i(h1_rdata), .soft_reset_o(soft_reset)
    );

    host_bus_port u_host_bus_port (
        .pclk(pclk), .rst_n_i(rst_n_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_data_i(bus_data_i),
        .bus_data_o(bus_data_o), .bus_out_en_o(bus_out_en_o),
        .req_o(h0_req), .wr_o(h0_wr), .bytesel_o(h0_bytesel), .reg_num_o(h0_reg_num),
        .wdata_o(h0_wdata), .ack_i(h0_ack), .rdata_i(h0_rdata)
    );

    reg_arbiter u_reg_arbiter (
        .pclk(pclk), .rst_n_i(rst_n_i),
        .h0_req_i(h0_req), .h0_wr_i(h0_wr), .h0_bytesel_i(h0_bytesel),
        .h0_reg_num_i(h0_reg_num), .h0_wdata_i(h0_wdata),
        .h0_ack_o(h0_ack), .h0_rdata_o(h0_rdata),
        .h1_req_i(h1_req), .h1_wr_i(h1_wr), .h1_bytesel_i(h1_bytesel),
        .h1_reg_num_i(h1_reg_num), .h1_wdata_i(h1_wdata),
        .h1_ack_o(h1_ack), .h1_rdata_o(h1_rdata),
        .sel_o(reg_sel), .wr_o(reg_wr), .bytesel_o(reg_bytesel), .reg_num_o(reg_num),
        .wdata_o(reg_wdata), .rdata_i(reg_rdata)
    );

    xv_regs u_xv_regs (
        .pclk(pclk), .rst_n_i(rst_n_i), .soft_reset_i(soft_reset),
        .sel_i(reg_sel), .wr_i(reg_wr), .bytesel_i(reg_bytesel), .reg_num_i(reg_num),
        .wdata_i(reg_wdata), .rdata_o(reg_rdata)
    );

endmodule

// ==== verif/xv_tb_tasks.svh ====
// bus cycles, SPI packets, random data and checks, included into the host register testbench
`ifndef XV_TB_TASKS_SVH
`define XV_TB_TASKS_SVH

// right-shifting Galois form, taps for x^8+x^6+x^5+x^4+1
function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    return state[0] ? ((state >> 1) ^ 8'hB8) : (state >> 1);
endfunction

task automatic rand_byte(output logic [7:0] value);
    value = '0;
    for (int i = 0; i < 8; i++) begin
        value = {value[6:0], lfsr_state[0]};   // one step per bit taken
        lfsr_state = lfsr_next(lfsr_state);
    end
endtask

task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] expected);
    check_count++;
    assert (got === expected)
    else begin
        err_count++;
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
    end
endtask

task automatic report_test(input string name);
    test_count++;
    $display("test %s finished, %0d errors", name, err_count - err_mark);
    err_mark = err_count;
endtask

task automatic model_write(input logic [3:0] reg_num, input logic bytesel, input logic [7:0] data);
    if (bytesel == BYTESEL_EVEN) begin
        model[reg_num][15:8] = data;            // even select is the high byte
    end else begin
        model[reg_num][7:0] = data;
    end
endtask

task automatic bus_write(input logic [3:0] reg_num, input logic bytesel, input logic [7:0] data);
    @(negedge pclk);
    bus_rd_nwr  = RNW_WRITE;
    bus_bytesel = bytesel;
    bus_reg_num = reg_num;
    bus_data_in = data;
    bus_cs_n    = CS_ENABLED;                   // fields and cs share the synchronizer depth
    repeat (10) @(negedge pclk);                // request at 3, ack at 5, 7 if the SPI host wins
    bus_cs_n = ~CS_ENABLED;
    repeat (4) @(negedge pclk);                 // port sees the bus idle again
    model_write(reg_num, bytesel, data);
endtask

task automatic bus_read(input logic [3:0] reg_num, input logic bytesel, output logic [7:0] data);
    @(negedge pclk);
    bus_rd_nwr  = RNW_READ;
    bus_bytesel = bytesel;
    bus_reg_num = reg_num;
    bus_cs_n    = CS_ENABLED;
    @(negedge pclk);
    while (bus_out_en !== 1'b1) @(negedge pclk);   // output enable marks the read data
    data = bus_data_out;
    bus_cs_n = ~CS_ENABLED;
    @(negedge pclk);
    check_value("bus_out_en_o 1 cycle after cs rise", 8'(bus_out_en), 8'd1);
    @(negedge pclk);
    check_value("bus_out_en_o 2 cycles after cs rise", 8'(bus_out_en), 8'd0);
    repeat (2) @(negedge pclk);
endtask

task automatic check_reg_bus(input logic [3:0] reg_num);
    logic [7:0] hi, lo;
    bus_read(reg_num, BYTESEL_EVEN, hi);
    bus_read(reg_num, BYTESEL_ODD, lo);
    check_value($sformatf("bus_data_o reg %0d high byte", reg_num), hi, model[reg_num][15:8]);
    check_value($sformatf("bus_data_o reg %0d low byte", reg_num), lo, model[reg_num][7:0]);
endtask

// one command byte and one payload byte in mode 0, MSB first
task automatic spi_packet(input logic [7:0] cmd, input logic [7:0] payload, output logic [15:0] rx);
    logic [15:0] tx;
    tx = {cmd, payload};
    rx = '0;
    @(negedge pclk);
    spi_cs_n = 1'b0;
    for (int i = 15; i >= 0; i--) begin
        spi_copi = tx[i];
        repeat (SCK_HALF) @(negedge pclk);
        rx = {rx[14:0], spi_cipo};              // host samples on the rising edge
        spi_sck = 1'b1;
        if (i == 0) spi_last_edge = 1'b1;
        repeat (SCK_HALF) @(negedge pclk);
        spi_sck = 1'b0;
    end
    repeat (SCK_HALF) @(negedge pclk);
    spi_cs_n = 1'b1;
    repeat (SCK_HALF) @(negedge pclk);
    spi_last_edge = 1'b0;
endtask

function automatic logic [7:0] spi_command(input logic wr, input logic bytesel,
                                           input logic [3:0] reg_num);
    logic [7:0] cmd;
    cmd = 8'h00;
    cmd[CMD_CS_BIT] = 1'b1;
    cmd[CMD_WR_BIT] = wr;
    cmd[CMD_BS_BIT] = bytesel;
    cmd[CMD_REG_LSB +: REG_NUM_W] = reg_num;
    return cmd;
endfunction

task automatic spi_write(input logic [3:0] reg_num, input logic bytesel, input logic [7:0] data);
    logic [15:0] rx;
    spi_packet(spi_command(1'b1, bytesel, reg_num), data, rx);
    check_value("spi_cipo_o during command byte", rx[15:8], SPI_IDLE_BYTE);
    model_write(reg_num, bytesel, data);
endtask

task automatic spi_read(input logic [3:0] reg_num, input logic bytesel, output logic [7:0] data);
    logic [15:0] rx;
    spi_packet(spi_command(1'b0, bytesel, reg_num), 8'h00, rx);
    check_value("spi_cipo_o during command byte", rx[15:8], SPI_IDLE_BYTE);
    data = rx[7:0];                             // read data rides the payload byte
endtask

task automatic spi_soft_reset();
    logic [7:0]  cmd;
    logic [15:0] rx;
    cmd = 8'h00;
    cmd[CMD_RS_BIT] = 1'b1;                     // no bus cycle, reset only
    spi_packet(cmd, 8'h00, rx);
    check_value("spi_cipo_o during command byte", rx[15:8], SPI_IDLE_BYTE);
    foreach (model[i]) model[i] = '0;
endtask

`endif

// ==== verif/xv_host_tb.sv ====
// self-checking testbench for the host register subsystem, drives both hosts through directed tests
`timescale 1ns/1ps

module xv_host_tb
    import xv_bus_pkg::*;
    import xv_spi_pkg::*;
();

    localparam int SCK_HALF       = 8;      // pclk periods per SCK phase, 16 per bit
    localparam int TIMEOUT_CYCLES = 4000;   // tests take about 2400 cycles, mostly SPI packets

    logic                 pclk = 1'b0;
    logic                 rst_n;
    logic                 bus_cs_n, bus_rd_nwr, bus_bytesel;
    logic [REG_NUM_W-1:0] bus_reg_num;
    logic [BYTE_W-1:0]    bus_data_in, bus_data_out;
    logic                 bus_out_en;
    logic                 spi_sck, spi_copi, spi_cs_n, spi_cipo;
    logic [REG_W-1:0]     model [REG_COUNT];   // expected register contents
    logic [7:0]           lfsr_state;
    logic                 spi_last_edge;       // high from the last SCK rise to the packet end
    int                   cycle_count, err_count, check_count, test_count, err_mark;

    xv_host_top u_xv_host_top (
        .pclk(pclk), .rst_n_i(rst_n),
        .bus_cs_n_i(bus_cs_n), .bus_rd_nwr_i(bus_rd_nwr), .bus_bytesel_i(bus_bytesel),
        .bus_reg_num_i(bus_reg_num), .bus_data_i(bus_data_in),
        .bus_data_o(bus_data_out), .bus_out_en_o(bus_out_en),
        .spi_sck_i(spi_sck), .spi_copi_i(spi_copi), .spi_cs_n_i(spi_cs_n), .spi_cipo_o(spi_cipo)
    );

    always #5 pclk = ~pclk;                    // 100 MHz

    always @(posedge pclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    `include "xv_tb_tasks.svh"

    task automatic test_reset_values();
        logic [7:0] got;
        for (int r = 0; r < REG_COUNT; r++) begin
            check_reg_bus(REG_NUM_W'(r));
        end
        spi_read(4'd6, BYTESEL_ODD, got);
        check_value("spi_cipo_o reg 6 low byte", got, model[6][7:0]);
    endtask

    task automatic test_bus_write_read();
        logic [7:0] hi, lo;
        for (int r = 5; r <= 10; r += 5) begin
            rand_byte(hi);
            rand_byte(lo);
            bus_write(REG_NUM_W'(r), BYTESEL_EVEN, hi);
            bus_write(REG_NUM_W'(r), BYTESEL_ODD, lo);
            check_reg_bus(REG_NUM_W'(r));
        end
    endtask

    task automatic test_cross_host();
        logic [7:0] data, got;
        rand_byte(data);
        spi_write(4'd7, BYTESEL_EVEN, data);   // SPI in, parallel out
        check_reg_bus(4'd7);
        rand_byte(data);
        bus_write(4'd9, BYTESEL_ODD, data);    // parallel in, SPI out
        spi_read(4'd9, BYTESEL_ODD, got);
        check_value("spi_cipo_o reg 9 low byte", got, data);
    endtask

    task automatic test_byte_select();
        logic [7:0] data;
        rand_byte(data);
        bus_write(4'd12, BYTESEL_EVEN, data);
        rand_byte(data);
        bus_write(4'd12, BYTESEL_ODD, data);
        rand_byte(data);
        bus_write(4'd12, BYTESEL_EVEN, data);  // low byte kept
        check_reg_bus(4'd12);
        rand_byte(data);
        spi_write(4'd12, BYTESEL_ODD, data);   // high byte kept
        check_reg_bus(4'd12);
    endtask

    task automatic test_soft_reset();
        int written[5] = '{5, 7, 9, 10, 12};   // registers loaded by earlier tests
        spi_soft_reset();
        foreach (written[i]) check_reg_bus(REG_NUM_W'(written[i]));
    endtask

    task automatic test_concurrent();
        logic [7:0] d_spi, d_bus;
        rand_byte(d_spi);
        rand_byte(d_bus);
        fork
            spi_write(4'd3, BYTESEL_ODD, d_spi);
            begin
                wait (spi_last_edge);
                repeat (2) @(negedge pclk);    // both requests rise in the same pclk cycle
                bus_write(4'd14, BYTESEL_EVEN, d_bus);
            end
        join
        check_reg_bus(4'd3);
        check_reg_bus(4'd14);
    endtask

    initial begin
        rst_n         = 1'b0;
        bus_cs_n      = ~CS_ENABLED;
        bus_rd_nwr    = RNW_READ;
        bus_bytesel   = BYTESEL_EVEN;
        bus_reg_num   = '0;
        bus_data_in   = '0;
        spi_sck       = 1'b0;                  // mode 0 idles low
        spi_copi      = 1'b0;
        spi_cs_n      = 1'b1;
        spi_last_edge = 1'b0;
        lfsr_state    = 8'd85;
        cycle_count   = 0;
        err_count     = 0;
        check_count   = 0;
        test_count    = 0;
        err_mark      = 0;
        foreach (model[i]) model[i] = '0;     // all registers clear after reset
        repeat (5) @(negedge pclk);
        rst_n = 1'b1;
        test_reset_values();
        report_test("reset_values");
        test_bus_write_read();
        report_test("bus_write_read");
        test_cross_host();
        report_test("cross_host");
        test_byte_select();
        report_test("byte_select");
        test_soft_reset();
        report_test("soft_reset");
        test_concurrent();
        report_test("concurrent_writes");
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verif
logic/xv_bus_pkg.sv
logic/xv_spi_pkg.sv
logic/spi_target.sv
logic/spi_bus_bridge.sv
logic/host_bus_port.sv
logic/reg_arbiter.sv
logic/xv_regs.sv
logic/xv_host_top.sv
verif/xv_host_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the host register testbench with Verilator, runs it and checks the log
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module xv_host_tb -o xv_host_sim

./obj_dir/xv_host_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
